// File: tb.f
+incdir+include
hw/nnPkg.sv
hw/neuron.sv
hw/denseLayer.sv
hw/apbRegs.sv
hw/nnAccel.sv
test/nnAccelTb.sv

// File: Makefile
SIM := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := nnAccelTb
FILELIST := tb.f
LOG := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/nnAccelTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "nn_config.svh"

module nnAccelTb
	import nnPkg::*;
();

	logic clk;
	logic reset;
	apbReq_t apbIn;
	apbRsp_t apbOut;

	logic [31:0] lcgState;
	actVec_t curActs;
	layerParams_t curParams;
	layerOut_t lastResult;

	// RESULT reads waiting for the comparing process
	layerOut_t expQ[$];
	layerOut_t gotQ[$];
	string nameQ[$];

	nnAccel DUT (
		.clk(clk),
		.reset(reset),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

	always #4 clk = ~clk;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkResult(input string name, input layerOut_t exp, input layerOut_t act);
		if (act !== exp)
			stopWithFailure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkData(input string name, input apbData_t exp, input apbData_t act);
		if (act !== exp)
			stopWithFailure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkErr(input string name, input logic exp, input logic act);
		if (act !== exp)
			stopWithFailure($sformatf("mismatch %s: expected pslverr %b, actual %b",
				name, exp, act));
	endtask

	task automatic checkReady(input string name, input logic exp, input logic act);
		if (act !== exp)
			stopWithFailure($sformatf("mismatch %s: expected pready %b, actual %b",
				name, exp, act));
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		// fold the upper bits down since the low LCG bits repeat quickly
		return lcgState ^ (lcgState >> 15);
	endfunction

	function automatic nodeOut_t neuronRef(input neuronParams_t p, input actVec_t a);
		int acc;
		int prod;
		acc = int'(p.bias) & 255;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			prod = int'(a[i]) * int'(p.weights[i]);
			acc = (acc + (prod & 255)) & 255;
		end
		// a sum of 128 or more is negative in 8 bits and the ReLU gives zero
		if (acc >= 128)
			return '0;
		return nodeOut_t'(acc);
	endfunction

	function automatic layerOut_t layerRef(input layerParams_t p, input actVec_t a);
		layerOut_t r;
		for (int n = 0; n < `NN_NEURONS; n++)
			r[n] = neuronRef(p[n], a);
		return r;
	endfunction

	// the weight words come first and the bias word follows
	function automatic apbAddr_t neuronAddr(input int n, input int word);
		return apbAddr_t'(`REG_WEIGHT_BASE + n * `REG_NEURON_STRIDE + 4 * word);
	endfunction

	task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t wdata,
		output apbData_t rdata, output logic err);
		@(negedge clk);
		apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apbIn.penable = 1'b1;
		// response is settled long before the closing edge
		#1;
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		checkReady($sformatf("access at %h", addr), 1'b1, apbOut.pready);
		@(negedge clk);
		apbIn = '0;
	endtask

	task automatic apbWrite(input apbAddr_t addr, input apbData_t data, output logic err);
		apbData_t ignored;
		apbTransfer(1'b1, addr, data, ignored, err);
	endtask

	task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err);
		apbTransfer(1'b0, addr, '0, data, err);
	endtask

	task automatic writeOk(input string name, input apbAddr_t addr, input apbData_t data);
		logic err;
		apbWrite(addr, data, err);
		checkErr(name, 1'b0, err);
	endtask

	task automatic readCheck(input string name, input apbAddr_t addr, input apbData_t exp);
		apbData_t data;
		logic err;
		apbRead(addr, data, err);
		checkErr(name, 1'b0, err);
		checkData(name, exp, data);
	endtask

	task automatic randomLayer();
		for (int w = 0; w < `NN_INPUTS / 4; w++)
			curActs[4 * w +: 4] = nextRand();
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int w = 0; w < `NN_INPUTS / 4; w++)
				curParams[n].weights[4 * w +: 4] = nextRand();
			curParams[n].bias = weight_t'(nextRand());
		end
	endtask

	task automatic loadLayer();
		for (int w = 0; w < `NN_INPUTS / 4; w++)
			writeOk("act write", `REG_ACT_BASE + apbAddr_t'(4 * w), curActs[4 * w +: 4]);
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int w = 0; w < `NN_INPUTS / 4; w++)
				writeOk("weight write", neuronAddr(n, w), curParams[n].weights[4 * w +: 4]);
			writeOk("bias write", neuronAddr(n, `NN_INPUTS / 4), {24'h0, curParams[n].bias});
		end
	endtask

	task automatic waitDone(input string name);
		apbData_t status;
		logic err;
		int polls;
		status = '0;
		polls = 0;
		while (status[0] !== 1'b1)
		begin
			if (polls == 20)
				stopWithFailure($sformatf("%s: done bit was never set after start", name));
			apbRead(`REG_STATUS, status, err);
			polls++;
		end
		// done set and busy clear
		checkData(name, 32'h1, status);
	endtask

	task automatic queueResultCheck(input string name, input layerOut_t exp);
		apbData_t data;
		logic err;
		apbRead(`REG_RESULT, data, err);
		checkErr(name, 1'b0, err);
		expQ.push_back(exp);
		gotQ.push_back(layerOut_t'(data));
		nameQ.push_back(name);
	endtask

	always @(posedge clk)
	begin
		if (expQ.size() > 0)
			checkResult(nameQ.pop_front(), expQ.pop_front(), gotQ.pop_front());
	end

	initial
	begin
		apbData_t data;
		logic err;
		int drain;
		clk = 1'b0;
		reset = 1'b1;
		apbIn = '0;
		lcgState = 32'hd25316b4;
		curActs = '0;
		curParams = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		readCheck("reset status", `REG_STATUS, '0);
		readCheck("reset result", `REG_RESULT, '0);
		readCheck("reset weight", neuronAddr(0, 0), '0);
		readCheck("reset act", `REG_ACT_BASE, '0);

		for (int w = 0; w < `NN_INPUTS / 4; w++)
		begin
			data = nextRand();
			writeOk("act write", `REG_ACT_BASE + apbAddr_t'(4 * w), data);
			readCheck("act readback", `REG_ACT_BASE + apbAddr_t'(4 * w), data);
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int word = 0; word <= `NN_INPUTS / 4; word++)
			begin
				data = nextRand();
				writeOk("param write", neuronAddr(n, word), data);
				// bias word keeps its low byte only
				if (word == `NN_INPUTS / 4)
					data = {24'h0, data[7:0]};
				readCheck("param readback", neuronAddr(n, word), data);
			end
		end

		for (int round = 0; round < 20; round++)
		begin
			randomLayer();
			if (round == 0)
			begin
				// ones against weights of -1 and a bias of -16 make every sum negative
				curActs = {`NN_INPUTS{8'h01}};
				for (int n = 0; n < `NN_NEURONS; n++)
					curParams[n] = {{`NN_INPUTS{8'hff}}, 8'hf0};
			end
			if (round == 1)
			begin
				// 100 times 3 overflows a byte
				curActs = {`NN_INPUTS{8'h64}};
				for (int n = 0; n < `NN_NEURONS; n++)
					curParams[n].weights = {`NN_INPUTS{8'h03}};
			end
			loadLayer();
			writeOk("start", `REG_CTRL, 32'h1);
			waitDone($sformatf("evaluation round %0d", round));
			queueResultCheck($sformatf("evaluation round %0d", round),
				layerRef(curParams, curActs));
		end

		repeat (3)
			readCheck("done held", `REG_STATUS, 32'h1);
		writeOk("restart", `REG_CTRL, 32'h1);
		readCheck("done cleared by start", `REG_STATUS, 32'h2);
		waitDone("restart");
		lastResult = layerRef(curParams, curActs);
		queueResultCheck("restart result", lastResult);

		apbRead(12'h100, data, err);
		checkErr("unmapped read", 1'b1, err);
		apbRead(`REG_ACT_BASE + 12'h1, data, err);
		checkErr("misaligned read", 1'b1, err);
		apbWrite(neuronAddr(0, 0) + 12'h2, 32'hffff_ffff, err);
		checkErr("misaligned write", 1'b1, err);
		apbWrite(`REG_STATUS, 32'h3, err);
		checkErr("status write", 1'b1, err);
		apbWrite(`REG_RESULT, 32'h5a5a_5a5a, err);
		checkErr("result write", 1'b1, err);
		queueResultCheck("result after errors", lastResult);
		readCheck("weight after misaligned write", neuronAddr(0, 0),
			curParams[0].weights[3:0]);

		// the second start lands while the layer is still running
		randomLayer();
		loadLayer();
		writeOk("first start", `REG_CTRL, 32'h1);
		writeOk("start while busy", `REG_CTRL, 32'h1);
		waitDone("start while busy");
		queueResultCheck("start while busy result", layerRef(curParams, curActs));

		drain = 0;
		while (expQ.size() > 0)
		begin
			if (drain == 10)
				stopWithFailure("pending result comparisons did not complete");
			@(posedge clk);
			drain++;
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/nnAccel.sv
`timescale 1ns/1ns
`default_nettype none

module nnAccel
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input apbReq_t apbIn,
	output apbRsp_t apbOut
);

	actVec_t acts;
	layerParams_t params;
	layerOut_t results;
	logic start;
	logic valid;

	// host side register file and controller
	apbRegs regs (
		.clk(clk),
		.reset(reset),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.acts(acts),
		.params(params),
		.start(start),
		.results(results),
		.valid(valid)
	);

	denseLayer layer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.acts(acts),
		.params(params),
		.results(results),
		.valid(valid)
	);

endmodule

`default_nettype wire

// File: hw/apbRegs.sv
`timescale 1ns/1ns
`default_nettype none

`include "nn_config.svh"

module apbRegs
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input apbReq_t apbIn,
	output apbRsp_t apbOut,
	output actVec_t acts,
	output layerParams_t params,
	output logic start,
	input layerOut_t results,
	input logic valid
);

	ctrlState_t state;
	logic busy;
	logic done;
	layerOut_t resultReg;

	logic access;
	logic wrEn;
	logic hit;
	logic slvErr;
	apbData_t rdData;

	logic selCtrl;
	logic selStatus;
	logic selResult;
	logic [`NN_INPUTS/4-1:0] selAct;
	logic [`NN_NEURONS-1:0][`NN_INPUTS/4-1:0] selWeight;
	logic [`NN_NEURONS-1:0] selBias;

	assign access = apbIn.psel && apbIn.penable;

	// address decode; misaligned addresses match nothing
	assign selCtrl = (apbIn.paddr == `REG_CTRL);
	assign selStatus = (apbIn.paddr == `REG_STATUS);
	assign selResult = (apbIn.paddr == `REG_RESULT);

	always_comb
	begin
		selAct = '0;
		selWeight = '0;
		selBias = '0;
		for (int w = 0; w < `NN_INPUTS / 4; w++)
		begin
			selAct[w] = (apbIn.paddr == apbAddr_t'(`REG_ACT_BASE + 4 * w));
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int w = 0; w < `NN_INPUTS / 4; w++)
			begin
				selWeight[n][w] = (apbIn.paddr ==
					apbAddr_t'(`REG_WEIGHT_BASE + n * `REG_NEURON_STRIDE + 4 * w));
			end
			// bias word follows the last weight word
			selBias[n] = (apbIn.paddr ==
				apbAddr_t'(`REG_WEIGHT_BASE + n * `REG_NEURON_STRIDE + `NN_INPUTS));
		end
	end

	assign hit = selCtrl || selStatus || selResult || (|selAct) || (|selWeight) || (|selBias);

	// status and result are read only
	assign slvErr = !hit || (apbIn.pwrite && (selStatus || selResult));
	assign wrEn = access && apbIn.pwrite && !slvErr;

	// read mux, ctrl reads as zero
	always_comb
	begin
		rdData = '0;
		if (selStatus)
		begin
			rdData[1:0] = {busy, done};
		end
		if (selResult)
		begin
			rdData = apbData_t'(resultReg);
		end
		for (int w = 0; w < `NN_INPUTS / 4; w++)
		begin
			if (selAct[w])
			begin
				rdData = acts[4 * w +: 4];
			end
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int w = 0; w < `NN_INPUTS / 4; w++)
			begin
				if (selWeight[n][w])
				begin
					rdData = params[n].weights[4 * w +: 4];
				end
			end
			if (selBias[n])
			begin
				rdData[7:0] = params[n].bias;
			end
		end
	end

	assign apbOut = '{prdata: rdData, pready: 1'b1, pslverr: access && slvErr};

	// activation, weight and bias registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acts <= '0;
			params <= '0;
		end
		else if (wrEn)
		begin
			for (int w = 0; w < `NN_INPUTS / 4; w++)
			begin
				if (selAct[w])
				begin
					acts[4 * w +: 4] <= apbIn.pwdata;
				end
			end
			for (int n = 0; n < `NN_NEURONS; n++)
			begin
				for (int w = 0; w < `NN_INPUTS / 4; w++)
				begin
					if (selWeight[n][w])
					begin
						params[n].weights[4 * w +: 4] <= apbIn.pwdata;
					end
				end
				if (selBias[n])
				begin
					params[n].bias <= apbIn.pwdata[7:0];
				end
			end
		end
	end

	// evaluation controller, a start while running is dropped
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			start <= 1'b0;
			done <= 1'b0;
			resultReg <= '0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				IDLE:
				begin
					if (wrEn && selCtrl && apbIn.pwdata[0])
					begin
						start <= 1'b1;
						done <= 1'b0;
						state <= RUN;
					end
				end
				RUN:
				begin
					if (valid)
					begin
						resultReg <= results;
						done <= 1'b1;
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign busy = (state == RUN);

	enableNeedsSel: assert property (
		@(posedge clk) disable iff (reset)
		apbIn.penable |-> apbIn.psel
	);

	// layer latency must land inside the run window
	validOnlyInRun: assert property (
		@(posedge clk) disable iff (reset)
		valid |-> (state == RUN)
	);

endmodule

`default_nettype wire

// File: hw/denseLayer.sv
`timescale 1ns/1ns
`default_nettype none

`include "nn_config.svh"

module denseLayer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input actVec_t acts,
	input layerParams_t params,
	output layerOut_t results,
	output logic valid
);

	// one bit per neuron pipeline stage
	logic [2:0] validPipe;

	// activations are broadcast, each neuron gets its own weights and bias
	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : genNeuron
		neuron node (
			.clk(clk),
			.reset(reset),
			.acts(acts),
			.params(params[n]),
			.result(results[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], start};
		end
	end

	assign valid = validPipe[2];

	validInReset: assert property (
		@(posedge clk)
		reset |=> !valid
	);

endmodule

`default_nettype wire

// File: hw/neuron.sv
`timescale 1ns/1ns
`default_nettype none

`include "nn_config.svh"

module neuron
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input actVec_t acts,
	input neuronParams_t params,
	output nodeOut_t result
);

	actVec_t actsReg;
	act_t sumNext;
	act_t sumReg;

	// stage 1, activations captured every cycle
	always_ff @(posedge clk)
	begin
		actsReg <= acts;
	end

	// low byte of each product, summed with the bias modulo 256
	always_comb
	begin
		sumNext = params.bias;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sumNext = sumNext + act_t'(actsReg[i] * params.weights[i]);
		end
	end

	// stage 2 holds the biased sum, stage 3 the ReLU output
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			if (sumReg[7] == 1'b0)
			begin
				result <= nodeOut_t'(sumReg);
			end
			else
			begin
				result <= '0;
			end
		end
	end

	// a negative sum must come out as zero one stage later
	reluClamp: assert property (
		@(posedge clk) disable iff (reset)
		sumReg[7] |=> (result == '0)
	);

endmodule

`default_nettype wire

// File: hw/nnPkg.sv
`default_nettype none

`include "nn_config.svh"

package nnPkg;

	typedef logic signed [7:0] act_t;
	typedef logic signed [7:0] weight_t;
	typedef logic [7:0] nodeOut_t;

	typedef act_t [`NN_INPUTS-1:0] actVec_t;
	typedef weight_t [`NN_INPUTS-1:0] weightVec_t;

	typedef struct packed {
		weightVec_t weights;
		weight_t bias;
	} neuronParams_t;

	typedef neuronParams_t [`NN_NEURONS-1:0] layerParams_t;

	// neuron 0 sits in the low byte
	typedef nodeOut_t [`NN_NEURONS-1:0] layerOut_t;

	typedef logic [`APB_ADDR_W-1:0] apbAddr_t;
	typedef logic [`APB_DATA_W-1:0] apbData_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbAddr_t paddr;
		apbData_t pwdata;
	} apbReq_t;

	typedef struct packed {
		apbData_t prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	typedef enum logic {
		IDLE,
		RUN
	} ctrlState_t;

endpackage

`default_nettype wire

// File: include/nn_config.svh
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// layer shape
`define NN_INPUTS 8
`define NN_NEURONS 4

// APB bus widths
`define APB_ADDR_W 12
`define APB_DATA_W 32

// register byte offsets
`define REG_CTRL 12'h000
`define REG_STATUS 12'h004
`define REG_ACT_BASE 12'h010
`define REG_RESULT 12'h020
`define REG_WEIGHT_BASE 12'h040

// each neuron owns weight words followed by one bias word
`define REG_NEURON_STRIDE 12'h010

`endif
